/* source/yolo_macros.svh */
`ifndef YOLO_MACROS_SVH
`define YOLO_MACROS_SVH

// engine geometry
`define YOLO_N_STAGES 4
`define YOLO_N_VECT 4

// external side
`define YOLO_IO_ADDR_W 32
`define YOLO_OFFSET_W 16

// internal generator and vector memory
`define YOLO_PIXEL_ADDR_W 10
`define YOLO_VWRITE_ADDR_W 8

// cpu register file
`define YOLO_CONF_ADDR_W 4

`endif

/* source/conf_pkg.sv */
`include "yolo_macros.svh"

package conf_pkg;

   typedef logic [`YOLO_CONF_ADDR_W-1:0] conf_addr_t;

   // cpu register map
   localparam conf_addr_t CONF_EXT_ADDR = 'd0;
   localparam conf_addr_t CONF_OFFSET   = 'd1;
   localparam conf_addr_t CONF_START    = 'd2;
   localparam conf_addr_t CONF_ITER     = 'd3;
   localparam conf_addr_t CONF_PER      = 'd4;
   localparam conf_addr_t CONF_SHIFT    = 'd5;
   localparam conf_addr_t CONF_INCR     = 'd6;
   localparam conf_addr_t CONF_DELAY    = 'd7;
   localparam conf_addr_t CONF_PP       = 'd8;
   localparam conf_addr_t CONF_BYPASS   = 'd9;

   // settings word for the write-address generator and lane router
   typedef struct packed {
      logic [`YOLO_VWRITE_ADDR_W-1:0] start;
      logic [`YOLO_PIXEL_ADDR_W-1:0]  iter;
      logic [`YOLO_PIXEL_ADDR_W-1:0]  per;
      logic [`YOLO_PIXEL_ADDR_W-1:0]  shift;
      logic [`YOLO_PIXEL_ADDR_W-1:0]  incr;
      logic [`YOLO_PIXEL_ADDR_W-1:0]  delay;
      logic                           bypass;
   } gen_conf_t;

endpackage

/* source/addr_pkg.sv */
`include "yolo_macros.svh"

package addr_pkg;

   // external memory address
   typedef logic [`YOLO_IO_ADDR_W-1:0] io_addr_t;

   // one base address per write stage
   typedef io_addr_t [`YOLO_N_STAGES-1:0] stage_addr_bus_t;

   // internal generator address
   typedef logic [`YOLO_PIXEL_ADDR_W-1:0] pix_addr_t;

   // one write enable per vector lane
   typedef logic [`YOLO_N_VECT-1:0] lane_en_t;

endpackage

/* source/conf_decode.sv */
`timescale 1ns/1ps

`include "yolo_macros.svh"

module conf_decode (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      clear,
   input  logic                      run,
   input  logic                      valid,
   input  conf_pkg::conf_addr_t      addr,
   input  addr_pkg::io_addr_t        wdata,
   input  logic                      wstrb,
   output addr_pkg::io_addr_t        base,
   output logic [`YOLO_OFFSET_W-1:0] offset,
   output conf_pkg::gen_conf_t       gen_conf
);

   localparam int N_REGS = int'(conf_pkg::CONF_BYPASS) + 1;
   localparam int START_MSB = `YOLO_VWRITE_ADDR_W - 1;

   logic [N_REGS-1:0]              reg_en;
   logic [`YOLO_VWRITE_ADDR_W-1:0] start_q;
   addr_pkg::pix_addr_t            iter_q;
   addr_pkg::pix_addr_t            per_q;
   addr_pkg::pix_addr_t            shift_q;
   addr_pkg::pix_addr_t            incr_q;
   addr_pkg::pix_addr_t            delay_q;
   logic                           pp_q;
   logic                           bypass_q;
   logic                           phase;

   // one enable per mapped register
   always_comb begin
      reg_en = '0;
      if (valid && wstrb) begin
         case (addr)
            conf_pkg::CONF_EXT_ADDR: reg_en[conf_pkg::CONF_EXT_ADDR] = 1'b1;
            conf_pkg::CONF_OFFSET:   reg_en[conf_pkg::CONF_OFFSET] = 1'b1;
            conf_pkg::CONF_START:    reg_en[conf_pkg::CONF_START] = 1'b1;
            conf_pkg::CONF_ITER:     reg_en[conf_pkg::CONF_ITER] = 1'b1;
            conf_pkg::CONF_PER:      reg_en[conf_pkg::CONF_PER] = 1'b1;
            conf_pkg::CONF_SHIFT:    reg_en[conf_pkg::CONF_SHIFT] = 1'b1;
            conf_pkg::CONF_INCR:     reg_en[conf_pkg::CONF_INCR] = 1'b1;
            conf_pkg::CONF_DELAY:    reg_en[conf_pkg::CONF_DELAY] = 1'b1;
            conf_pkg::CONF_PP:       reg_en[conf_pkg::CONF_PP] = 1'b1;
            conf_pkg::CONF_BYPASS:   reg_en[conf_pkg::CONF_BYPASS] = 1'b1;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         base     <= '0;
         offset   <= '0;
         start_q  <= '0;
         iter_q   <= '0;
         per_q    <= '0;
         shift_q  <= '0;
         incr_q   <= '0;
         delay_q  <= '0;
         pp_q     <= 1'b0;
         bypass_q <= 1'b0;
      end else if (clear) begin
         base     <= '0;
         offset   <= '0;
         start_q  <= '0;
         iter_q   <= '0;
         per_q    <= '0;
         shift_q  <= '0;
         incr_q   <= '0;
         delay_q  <= '0;
         pp_q     <= 1'b0;
         bypass_q <= 1'b0;
      end else begin
         if (reg_en[conf_pkg::CONF_EXT_ADDR])
            base <= wdata;
         if (reg_en[conf_pkg::CONF_OFFSET])
            offset <= wdata[`YOLO_OFFSET_W-1:0];
         if (reg_en[conf_pkg::CONF_START])
            start_q <= wdata[`YOLO_VWRITE_ADDR_W-1:0];
         if (reg_en[conf_pkg::CONF_ITER])
            iter_q <= wdata[`YOLO_PIXEL_ADDR_W-1:0];
         if (reg_en[conf_pkg::CONF_PER])
            per_q <= wdata[`YOLO_PIXEL_ADDR_W-1:0];
         if (reg_en[conf_pkg::CONF_SHIFT])
            shift_q <= wdata[`YOLO_PIXEL_ADDR_W-1:0];
         if (reg_en[conf_pkg::CONF_INCR])
            incr_q <= wdata[`YOLO_PIXEL_ADDR_W-1:0];
         if (reg_en[conf_pkg::CONF_DELAY])
            delay_q <= wdata[`YOLO_PIXEL_ADDR_W-1:0];
         if (reg_en[conf_pkg::CONF_PP])
            pp_q <= wdata[0];
         if (reg_en[conf_pkg::CONF_BYPASS])
            bypass_q <= wdata[0];
      end
   end

   // ping-pong phase, flips once per layer
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         phase <= 1'b0;
      else if (clear)
         phase <= 1'b0;
      else if (run && pp_q)
         phase <= ~phase;
   end

   // start msb selects the half of the vector memory
   always_comb begin
      gen_conf.start  = {start_q[START_MSB] ^ (pp_q & phase), start_q[START_MSB-1:0]};
      gen_conf.iter   = iter_q;
      gen_conf.per    = per_q;
      gen_conf.shift  = shift_q;
      gen_conf.incr   = incr_q;
      gen_conf.delay  = delay_q;
      gen_conf.bypass = bypass_q;
   end

   a_addr_known: assert property (@(posedge clk) disable iff (rst)
      (valid && wstrb) |-> !$isunknown(addr));

endmodule

/* source/shadow_pipe.sv */
`timescale 1ns/1ps

module shadow_pipe #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     run,
   input  payload_t d,
   output payload_t q
);

   // next layer waits here while the current one runs
   payload_t slot;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         slot <= '0;
         q    <= '0;
      end else if (run) begin
         slot <= d;
         q    <= slot;
      end
   end

endmodule

/* source/stage_addr_calc.sv */
`timescale 1ns/1ps

`include "yolo_macros.svh"

module stage_addr_calc (
   input  logic                      clk,
   input  logic                      rst,
   input  addr_pkg::io_addr_t        base,
   input  logic [`YOLO_OFFSET_W-1:0] offset,
   output addr_pkg::stage_addr_bus_t stage_addr
);

   addr_pkg::io_addr_t        offset_ext;
   addr_pkg::stage_addr_bus_t mac;

   assign offset_ext = addr_pkg::io_addr_t'(offset);

   // base plus lane index times offset
   for (genvar i = 0; i < `YOLO_N_STAGES; i++) begin : g_lane
      if (i == 0) begin : g_base
         assign mac[i] = base;
      end else begin : g_mac
         assign mac[i] = base + addr_pkg::io_addr_t'(i) * offset_ext;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         stage_addr <= '0;
      else
         stage_addr <= mac;
   end

endmodule

/* source/addr_gen.sv */
`timescale 1ns/1ps

`include "yolo_macros.svh"

module addr_gen (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           run,
   input  logic [`YOLO_VWRITE_ADDR_W-1:0] start,
   input  addr_pkg::pix_addr_t            iter,
   input  addr_pkg::pix_addr_t            per,
   input  addr_pkg::pix_addr_t            shift,
   input  addr_pkg::pix_addr_t            incr,
   input  addr_pkg::pix_addr_t            delay,
   output logic                           gen_en,
   output addr_pkg::pix_addr_t            gen_addr,
   output logic                           done
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_WAIT,
      S_GEN
   } state_t;

   state_t              state;
   logic                run_q;
   logic                done_q;
   logic                empty;
   addr_pkg::pix_addr_t delay_cnt;
   addr_pkg::pix_addr_t p_cnt;
   addr_pkg::pix_addr_t it_cnt;

   assign empty  = (iter == '0) || (per == '0);
   assign gen_en = (state == S_GEN);
   // drop done already in the cycle the new layer is picked up
   assign done   = done_q && !(run_q && !empty);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= S_IDLE;
         run_q     <= 1'b0;
         done_q    <= 1'b1;
         delay_cnt <= '0;
         p_cnt     <= '0;
         it_cnt    <= '0;
         gen_addr  <= '0;
      end else begin
         run_q <= run;
         if (run_q) begin
            delay_cnt <= delay;
            p_cnt     <= '0;
            it_cnt    <= '0;
            gen_addr  <= addr_pkg::pix_addr_t'(start);
            if (empty) begin
               state  <= S_IDLE;
               done_q <= 1'b1;
            end else begin
               state  <= S_WAIT;
               done_q <= 1'b0;
            end
         end else begin
            case (state)
               S_WAIT: begin
                  if (delay_cnt == '0)
                     state <= S_GEN;
                  else
                     delay_cnt <= delay_cnt - 1'b1;
               end
               S_GEN: begin
                  // end of period jumps by shift instead of incr
                  if (p_cnt == per - 1'b1) begin
                     p_cnt    <= '0;
                     gen_addr <= gen_addr + shift;
                     if (it_cnt == iter - 1'b1) begin
                        state  <= S_IDLE;
                        done_q <= 1'b1;
                     end else begin
                        it_cnt <= it_cnt + 1'b1;
                     end
                  end else begin
                     p_cnt    <= p_cnt + 1'b1;
                     gen_addr <= gen_addr + incr;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   a_no_en_when_done: assert property (@(posedge clk) disable iff (rst)
      gen_en |-> !done);

endmodule

/* source/write_enable_route.sv */
`timescale 1ns/1ps

`include "yolo_macros.svh"

module write_enable_route (
   input  logic                clk,
   input  logic                rst,
   input  logic                run,
   input  logic                bypass,
   input  logic                gen_en,
   input  addr_pkg::pix_addr_t gen_addr,
   output addr_pkg::lane_en_t  wr_en,
   output addr_pkg::pix_addr_t wr_addr
);

   localparam int N_VECT = `YOLO_N_VECT;
   // one spare bit so the saturated count never hits a lane slot
   localparam int CNT_W = $clog2(4 * N_VECT) + 1;

   logic                en_q;
   logic [CNT_W-1:0]    en_cnt;
   addr_pkg::pix_addr_t addr_q;
   addr_pkg::lane_en_t  lane_sel;

   // bypass keeps every fourth enable, one lane at a time
   always_comb begin
      for (int j = 0; j < N_VECT; j++) begin
         if (bypass)
            lane_sel[j] = en_q && (en_cnt == CNT_W'(4 * j + 3));
         else
            lane_sel[j] = gen_en;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         en_q   <= 1'b0;
         en_cnt <= '0;
         wr_en  <= '0;
      end else begin
         en_q  <= gen_en;
         wr_en <= lane_sel;
         if (run)
            en_cnt <= '0;
         else if (en_q && (en_cnt != '1))
            en_cnt <= en_cnt + 1'b1;
      end
   end

   // extra address stage in bypass to line up with the lane select
   always_ff @(posedge clk) begin
      addr_q  <= gen_addr;
      wr_addr <= bypass ? addr_q : gen_addr;
   end

   a_bypass_onehot: assert property (@(posedge clk) disable iff (rst)
      (bypass && $past(bypass)) |-> $onehot0(wr_en));

endmodule

/* source/yolo_write_ctrl.sv */
`timescale 1ns/1ps

`include "yolo_macros.svh"

module yolo_write_ctrl (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      clear,
   input  logic                      run,
   input  logic                      valid,
   input  conf_pkg::conf_addr_t      addr,
   input  addr_pkg::io_addr_t        wdata,
   input  logic                      wstrb,
   output addr_pkg::stage_addr_bus_t stage_ext_addr,
   output addr_pkg::lane_en_t        wr_en,
   output addr_pkg::pix_addr_t       wr_addr,
   output logic                      done
);

   addr_pkg::io_addr_t        base;
   logic [`YOLO_OFFSET_W-1:0] offset;
   conf_pkg::gen_conf_t       gen_conf_raw;
   conf_pkg::gen_conf_t       gen_conf_q;
   addr_pkg::stage_addr_bus_t stage_addr;
   logic                      gen_en;
   addr_pkg::pix_addr_t       gen_addr;

   conf_decode u_decode (
      .clk      (clk),
      .rst      (rst),
      .clear    (clear),
      .run      (run),
      .valid    (valid),
      .addr     (addr),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .base     (base),
      .offset   (offset),
      .gen_conf (gen_conf_raw)
   );

   stage_addr_calc u_stage_addr (
      .clk        (clk),
      .rst        (rst),
      .base       (base),
      .offset     (offset),
      .stage_addr (stage_addr)
   );

   shadow_pipe #(
      .payload_t (conf_pkg::gen_conf_t)
   ) conf_pipe (
      .clk (clk),
      .rst (rst),
      .run (run),
      .d   (gen_conf_raw),
      .q   (gen_conf_q)
   );

   shadow_pipe #(
      .payload_t (addr_pkg::stage_addr_bus_t)
   ) addr_pipe (
      .clk (clk),
      .rst (rst),
      .run (run),
      .d   (stage_addr),
      .q   (stage_ext_addr)
   );

   addr_gen u_execute (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .start    (gen_conf_q.start),
      .iter     (gen_conf_q.iter),
      .per      (gen_conf_q.per),
      .shift    (gen_conf_q.shift),
      .incr     (gen_conf_q.incr),
      .delay    (gen_conf_q.delay),
      .gen_en   (gen_en),
      .gen_addr (gen_addr),
      .done     (done)
   );

   write_enable_route u_result (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .bypass   (gen_conf_q.bypass),
      .gen_en   (gen_en),
      .gen_addr (gen_addr),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr)
   );

endmodule

/* verif/tb_yolo_write_ctrl.sv */
`timescale 1ns/1ps

module tb_yolo_write_ctrl;

   // one table row: register writes or a clear, then a run
   typedef struct {
      bit          do_clear;
      bit          rnd;
      int          n_en;
      logic [31:0] base;
      logic [31:0] offset;
      logic [31:0] start;
      logic [31:0] iter;
      logic [31:0] per;
      logic [31:0] shift;
      logic [31:0] incr;
      logic [31:0] delay;
      logic [31:0] pp;
      logic [31:0] bypass;
   } row_t;

   logic                      clk;
   logic                      rst;
   logic                      clear;
   logic                      run;
   logic                      valid;
   logic                      wstrb;
   conf_pkg::conf_addr_t      addr;
   addr_pkg::io_addr_t        wdata;
   addr_pkg::stage_addr_bus_t stage_ext_addr;
   addr_pkg::lane_en_t        wr_en;
   addr_pkg::pix_addr_t       wr_addr;
   logic                      done;

   row_t        tbl[$];
   logic [31:0] lcg_state = 32'd77161;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          limit = 0;
   int          seen = 0;
   logic [3:0]  exp_mask[$];
   logic [9:0]  exp_addr[$];

   // reference model state
   row_t         cur;
   row_t         slot_cfg;
   row_t         shadow_cfg;
   logic         phase;
   logic [127:0] slot_stage;
   logic [127:0] shadow_stage;

   yolo_write_ctrl dut (
      .clk            (clk),
      .rst            (rst),
      .clear          (clear),
      .run            (run),
      .valid          (valid),
      .addr           (addr),
      .wdata          (wdata),
      .wstrb          (wstrb),
      .stage_ext_addr (stage_ext_addr),
      .wr_en          (wr_en),
      .wr_addr        (wr_addr),
      .done           (done)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      end
   endtask

   task automatic add_row(input bit clr, input bit rnd, input int n_en, input logic [31:0] base,
                          input logic [31:0] offset, input logic [31:0] start,
                          input logic [31:0] iter, input logic [31:0] per,
                          input logic [31:0] shift, input logic [31:0] incr,
                          input logic [31:0] delay, input logic [31:0] pp,
                          input logic [31:0] bypass);
      row_t r;
      r = '{do_clear: clr, rnd: rnd, n_en: n_en, base: base, offset: offset, start: start,
            iter: iter, per: per, shift: shift, incr: incr, delay: delay, pp: pp,
            bypass: bypass};
      if (rnd) begin
         r.base   = lcg_next();
         r.offset = lcg_next() & 32'hffff;
         r.start  = lcg_next() & 32'hff;
      end
      tbl.push_back(r);
   endtask

   // base plus stage index times offset, 32-bit wrap
   function automatic logic [127:0] stage_of(input row_t r);
      logic [127:0] s;
      logic [31:0]  idx;
      for (int i = 0; i < 4; i++) begin
         idx = i;
         s[i*32 +: 32] = r.base + idx * r.offset;
      end
      return s;
   endfunction

   task automatic expect_layer(input row_t c);
      logic [31:0] a;
      logic [31:0] k;
      k = 0;
      for (int it = 0; it < int'(c.iter); it++) begin
         for (int p = 0; p < int'(c.per); p++) begin
            a = c.start + it * ((c.per - 1) * c.incr + c.shift) + p * c.incr;
            if (c.bypass == 0) begin
               exp_mask.push_back(4'hf);
               exp_addr.push_back(a[9:0]);
            end else if (k % 4 == 3 && k < 16) begin
               exp_mask.push_back(4'b0001 << (k / 4));
               exp_addr.push_back(a[9:0]);
            end
            k++;
         end
      end
   endtask

   // run moves the written settings into the slot and the slot into the shadow
   task automatic model_run();
      shadow_cfg   = slot_cfg;
      shadow_stage = slot_stage;
      slot_cfg     = cur;
      if (cur.pp[0] && phase)
         slot_cfg.start = cur.start ^ 32'h80;
      slot_stage = stage_of(cur);
      if (cur.pp[0])
         phase = ~phase;
      expect_layer(shadow_cfg);
   endtask

   task automatic write_reg(input conf_pkg::conf_addr_t a, input logic [31:0] d);
      @(posedge clk);
      valid <= 1'b1;
      wstrb <= 1'b1;
      addr  <= a;
      wdata <= d;
   endtask

   task automatic wait_layer();
      if (shadow_cfg.iter != 0 && shadow_cfg.per != 0) begin
         @(negedge clk);
         while (done !== 1'b0)
            @(negedge clk);
         while (done !== 1'b1)
            @(negedge clk);
         // lane router latency
         repeat (4) @(negedge clk);
      end else begin
         repeat (6) begin
            @(negedge clk);
            check("done", 128'(done), 128'(1'b1));
         end
      end
   endtask

   task automatic apply_row(input row_t r);
      if (r.do_clear) begin
         @(posedge clk);
         clear <= 1'b1;
         @(posedge clk);
         clear <= 1'b0;
         cur   = '{default: '0};
         phase = 1'b0;
      end else begin
         write_reg(conf_pkg::CONF_EXT_ADDR, r.base);
         write_reg(conf_pkg::CONF_OFFSET, r.offset);
         write_reg(conf_pkg::CONF_START, r.start);
         write_reg(conf_pkg::CONF_ITER, r.iter);
         write_reg(conf_pkg::CONF_PER, r.per);
         write_reg(conf_pkg::CONF_SHIFT, r.shift);
         write_reg(conf_pkg::CONF_INCR, r.incr);
         write_reg(conf_pkg::CONF_DELAY, r.delay);
         write_reg(conf_pkg::CONF_PP, r.pp);
         write_reg(conf_pkg::CONF_BYPASS, r.bypass);
         // unmapped, must be ignored
         write_reg(4'd12, 32'hdead_beef);
         @(posedge clk);
         valid <= 1'b0;
         wstrb <= 1'b0;
         cur = r;
      end
      repeat (3) @(posedge clk);
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      seen = 0;
      model_run();
      wait_layer();
      check("stage_ext_addr", stage_ext_addr, shadow_stage);
      check("enable count", 128'(seen), 128'(r.n_en));
      if (exp_mask.size() != 0) begin
         errors++;
         $display("missing %0d expected write enables at t=%0t", exp_mask.size(), $time);
         exp_mask.delete();
         exp_addr.delete();
      end
   endtask

   // write enables in order against the model
   always @(negedge clk) begin
      if (!rst && wr_en !== '0) begin
         seen++;
         if (exp_mask.size() == 0) begin
            errors++;
            $display("unexpected write enable at t=%0t wr_en=%b wr_addr=%0h",
                     $time, wr_en, wr_addr);
         end else begin
            check("wr_en", 128'(wr_en), 128'(exp_mask.pop_front()));
            check("wr_addr", 128'(wr_addr), 128'(exp_addr.pop_front()));
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("TEST FAIL");
         $finish;
      end
   end

   initial begin
      rst          = 1'b1;
      clear        = 1'b0;
      run          = 1'b0;
      valid        = 1'b0;
      wstrb        = 1'b0;
      addr         = '0;
      wdata        = '0;
      cur          = '{default: '0};
      slot_cfg     = cur;
      shadow_cfg   = cur;
      phase        = 1'b0;
      slot_stage   = '0;
      shadow_stage = '0;

      // clr rnd n_en base offset start iter per shift incr delay pp bypass
      add_row(0, 0, 0, 32'h1000_0000, 32'h0100, 32'h10, 2, 3, 5, 1, 0, 0, 0);
      add_row(0, 1, 6, 0, 0, 0, 3, 2, 7, 2, 3, 0, 0);
      add_row(0, 0, 6, 32'h2000_0040, 32'h0400, 32'h20, 1, 2, 0, 1, 1, 1, 0);
      add_row(0, 0, 2, 32'h2000_0040, 32'h0400, 32'h20, 1, 2, 0, 1, 1, 1, 0);
      add_row(0, 0, 2, 32'h3000_0000, 32'hffff, 32'h40, 4, 5, 3, 1, 2, 0, 1);
      add_row(0, 1, 4, 0, 0, 0, 2, 2, 1, 4, 0, 0, 0);
      add_row(1, 0, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
      add_row(1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);

      limit = 8;
      foreach (tbl[i])
         limit += 2 * (int'(tbl[i].delay) + int'(tbl[i].iter * tbl[i].per) + 20);

      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check("done", 128'(done), 128'(1'b1));
      check("wr_en", 128'(wr_en), 128'(0));
      check("stage_ext_addr", stage_ext_addr, 128'(0));

      foreach (tbl[i])
         apply_row(tbl[i]);

      $display("checks=%0d errors=%0d", checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

/* all.f */
+incdir+source
source/conf_pkg.sv
source/addr_pkg.sv
source/conf_decode.sv
source/shadow_pipe.sv
source/stage_addr_calc.sv
source/addr_gen.sv
source/write_enable_route.sv
source/yolo_write_ctrl.sv
verif/tb_yolo_write_ctrl.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module tb_yolo_write_ctrl -o tb_sim
	@out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
